// File: atom_deserializer.sv
`timescale 1ns/100ps
`include "pool_params.svh"

module atom_deserializer (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_valid,	// Word from the input FIFO
	input  pool_pkg::word_t i_data,
	output logic            o_ready,
	output logic            o_valid,	// Complete atom waiting
	output pool_pkg::atom_t o_atom,
	input  logic            i_ready	// Lanes take the atom
);

	localparam int CNT_W = $clog2(`BURST_LEN);

	logic [CNT_W-1:0] word_cnt;	// Words gathered into the current atom
	logic             full_q;	// Atom complete, not yet taken
	logic             take;
	pool_pkg::atom_t  atom_q;	// Shift register, oldest word ends at index 0

	assign o_ready = !full_q;	// Hold off new words while the atom waits
	assign o_valid = full_q;
	assign o_atom  = atom_q;
	assign take    = i_valid && o_ready;

	// New word enters at the top and walks down one lane per word
	always_ff @(posedge clk) begin
		if (take) begin
			atom_q <= {i_data, atom_q[`BURST_LEN-1:1]};
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_cnt <= '0;
			full_q   <= 1'b0;
		end else if (take) begin
			if (word_cnt == CNT_W'(`BURST_LEN - 1)) begin
				word_cnt <= '0;
				full_q   <= 1'b1;	// Valid on the next cycle
			end else begin
				word_cnt <= word_cnt + 1'b1;
			end
		end else if (full_q && i_ready) begin
			full_q <= 1'b0;	// Atom handed to the lanes
		end
	end

endmodule

// File: atom_serializer.sv
`timescale 1ns/100ps
`include "pool_params.svh"

module atom_serializer (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_valid,	// Result atom from the FIFO
	input  pool_pkg::atom_t i_atom,
	output logic            o_ready,
	output logic            o_out_valid,	// One word, spends one credit
	output pool_pkg::word_t o_out_data,
	input  logic            i_out_credit,	// Receiver returns one credit
	output logic            o_atom_sent	// With the last word of an atom
);

	localparam int CRD_W = $clog2(`OUT_CREDITS + 1);
	localparam int IDX_W = $clog2(`BURST_LEN);

	logic [CRD_W-1:0] credits;	// Words the receiver can still take
	logic [IDX_W-1:0] word_idx;	// Next lane to send
	logic             busy_q;	// Atom loaded, words remain
	logic             send;
	logic             last_word;
	logic             take;
	pool_pkg::atom_t  atom_q;

	assign send      = busy_q && (credits != '0);
	assign last_word = (word_idx == IDX_W'(`BURST_LEN - 1));
	assign o_ready   = !busy_q || (send && last_word);	// Reload behind the last word
	assign take      = i_valid && o_ready;

	always_ff @(posedge clk) begin
		if (take) begin
			atom_q <= i_atom;
		end
		if (send) begin
			o_out_data <= atom_q[word_idx];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			credits     <= CRD_W'(`OUT_CREDITS);
			word_idx    <= '0;
			busy_q      <= 1'b0;
			o_out_valid <= 1'b0;
			o_atom_sent <= 1'b0;
		end else begin
			o_out_valid <= send;
			o_atom_sent <= send && last_word;
			case ({i_out_credit, send})	// Return and spend may coincide
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: ;
			endcase
			if (send) begin
				word_idx <= last_word ? '0 : word_idx + 1'b1;
			end
			if (take) begin
				busy_q <= 1'b1;
			end else if (send && last_word) begin
				busy_q <= 1'b0;
			end
		end
	end

	// Receiver only returns credits it holds, so the count stays within OUT_CREDITS
	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		i_out_credit |-> (credits < CRD_W'(`OUT_CREDITS)));

endmodule

// File: credit_fifo.sv
`timescale 1ns/100ps

module credit_fifo #(
	parameter type T     = logic [15:0],	// Payload type
	parameter int  DEPTH = 4	// Entries
) (
	input  logic clk,
	input  logic rst,
	input  logic i_valid,	// Write request
	input  T     i_data,
	output logic o_ready,	// At least one free entry
	output logic o_valid,	// Head entry present
	output T     o_data,
	input  logic i_ready	// Reader takes the head
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T                 mem [DEPTH];	// Circular storage
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;	// Occupancy
	logic             wr_en;
	logic             rd_en;

	// Wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign o_ready = (count != CNT_W'(DEPTH));
	assign o_valid = (count != '0);
	assign o_data  = mem[rd_ptr];	// Head shows the cycle after its write
	assign wr_en   = i_valid && o_ready;
	assign rd_en   = o_valid && i_ready;	// Pop strobe

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= i_data;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;	// Idle or simultaneous push and pop
			endcase
		end
	end

	// A word offered to a full buffer is lost unless the writer holds it
	a_write_held: assert property (@(posedge clk) disable iff (rst)
		(i_valid && !o_ready) |=> (i_valid && $stable(i_data)));
	// Head of a non-empty buffer is always a written entry
	a_head_known: assert property (@(posedge clk) disable iff (rst)
		o_valid |-> !$isunknown(o_data));

endmodule

// File: pool_ctrl.sv
`timescale 1ns/100ps

module pool_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_start,	// One cycle, with i_cfg
	input  pool_pkg::pool_cfg_t i_cfg,
	input  logic                i_atom_sent,	// One window left the serializer
	output pool_pkg::pool_cfg_t o_cfg,	// Held for the whole layer
	output logic                o_busy,
	output logic                o_done	// Pulse after the last window
);

	logic [15:0] win_done;	// Windows fully sent

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_cfg    <= '0;
			o_busy   <= 1'b0;
			o_done   <= 1'b0;
			win_done <= '0;
		end else begin
			o_done <= 1'b0;
			if (i_start && !o_busy) begin
				o_cfg    <= i_cfg;
				o_busy   <= 1'b1;
				win_done <= '0;
			end else if (o_busy && i_atom_sent) begin
				if (win_done == o_cfg.n_windows - 16'd1) begin
					o_busy   <= 1'b0;	// Falls together with done
					o_done   <= 1'b1;
					win_done <= '0;
				end else begin
					win_done <= win_done + 16'd1;
				end
			end
		end
	end

	// Host waits for done before the next layer
	a_start_idle: assert property (@(posedge clk) disable iff (rst)
		i_start |-> !o_busy);

endmodule

// File: pool_engine.sv
`timescale 1ns/100ps
`include "pool_params.svh"

module pool_engine (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_start,
	input  pool_pkg::pool_cfg_t i_cfg,
	input  logic                i_in_valid,	// Word in, host holds a credit
	input  pool_pkg::word_t     i_in_data,
	output logic                o_in_credit,	// One input credit back
	output logic                o_out_valid,	// Word out, spends a credit
	output pool_pkg::word_t     o_out_data,
	input  logic                i_out_credit,
	output logic                o_busy,
	output logic                o_done
);

	logic                in_valid;	// Input FIFO head
	pool_pkg::word_t     in_word;
	logic                deser_ready;
	logic                atom_valid;	// Deserializer to lanes
	pool_pkg::atom_t     atom;
	logic                lane_ready;
	logic                res_valid;	// Lanes to result FIFO
	pool_pkg::atom_t     res_atom;
	logic                res_ready;
	logic                out_valid;	// Result FIFO to serializer
	pool_pkg::atom_t     out_atom;
	logic                ser_ready;
	logic                atom_sent;
	pool_pkg::pool_cfg_t cfg;

	assign o_in_credit = in_valid && deser_ready;	// Input FIFO pop

	// Host credits guarantee room in the input FIFO
	credit_fifo #(.T(pool_pkg::word_t), .DEPTH(`IN_DEPTH)) u_in_fifo (
		.clk(clk), .rst(rst),
		.i_valid(i_in_valid), .i_data(i_in_data), .o_ready(),
		.o_valid(in_valid), .o_data(in_word), .i_ready(deser_ready)
	);

	atom_deserializer u_deser (
		.clk(clk), .rst(rst),
		.i_valid(in_valid), .i_data(in_word), .o_ready(deser_ready),
		.o_valid(atom_valid), .o_atom(atom), .i_ready(lane_ready)
	);

	pool_lane_array u_lanes (
		.clk(clk), .rst(rst), .i_cfg(cfg), .i_busy(o_busy),
		.i_valid(atom_valid), .i_atom(atom), .o_ready(lane_ready),
		.o_valid(res_valid), .o_atom(res_atom), .i_ready(res_ready)
	);

	credit_fifo #(.T(pool_pkg::atom_t), .DEPTH(`OUT_DEPTH)) u_res_fifo (
		.clk(clk), .rst(rst),
		.i_valid(res_valid), .i_data(res_atom), .o_ready(res_ready),
		.o_valid(out_valid), .o_data(out_atom), .i_ready(ser_ready)
	);

	atom_serializer u_ser (
		.clk(clk), .rst(rst),
		.i_valid(out_valid), .i_atom(out_atom), .o_ready(ser_ready),
		.o_out_valid(o_out_valid), .o_out_data(o_out_data),
		.i_out_credit(i_out_credit), .o_atom_sent(atom_sent)
	);

	pool_ctrl u_ctrl (
		.clk(clk), .rst(rst), .i_start(i_start), .i_cfg(i_cfg),
		.i_atom_sent(atom_sent), .o_cfg(cfg), .o_busy(o_busy), .o_done(o_done)
	);

endmodule

// File: pool_lane_array.sv
`timescale 1ns/100ps
`include "pool_params.svh"

module pool_lane_array (
	input  logic                clk,
	input  logic                rst,
	input  pool_pkg::pool_cfg_t i_cfg,	// Latched layer configuration
	input  logic                i_busy,	// Layer running
	input  logic                i_valid,	// Atom from the deserializer
	input  pool_pkg::atom_t     i_atom,
	output logic                o_ready,
	output logic                o_valid,	// Pooled atom toward the result FIFO
	output pool_pkg::atom_t     o_atom,
	input  logic                i_ready
);

	localparam int CNT_W = `MAX_WIN_SHIFT + 1;

	logic [CNT_W-1:0] win_cnt;	// Atoms taken in the current window
	logic [CNT_W-1:0] win_last_idx;
	logic             win_first;
	logic             win_last;
	logic             is_max;
	logic             take;
	pool_pkg::sum_t   acc_q [`BURST_LEN];	// Running max or sum per channel
	pool_pkg::word_t  res_q [`BURST_LEN];	// Finished window per channel

	assign win_last_idx = (CNT_W'(1) << i_cfg.win_shift) - 1'b1;
	assign win_first    = (win_cnt == '0);
	assign win_last     = (win_cnt == win_last_idx);
	assign is_max       = (i_cfg.op == pool_pkg::POOL_MAX);
	// Only a closing atom needs a free output register, the rest keep accumulating
	assign o_ready      = i_busy && (!win_last || !o_valid || i_ready);
	assign take         = i_valid && o_ready;

	for (genvar g = 0; g < `BURST_LEN; g++) begin : g_lane
		pool_pkg::sum_t in_ext;	// Channel value, zero extended
		pool_pkg::sum_t acc_next;
		pool_pkg::sum_t acc_shr;	// Floor divide by window length

		assign in_ext  = pool_pkg::sum_t'(i_atom[g]);
		assign acc_shr = acc_next >> i_cfg.win_shift;

		always_comb begin
			if (win_first) begin
				acc_next = in_ext;	// First atom loads
			end else if (is_max) begin
				acc_next = (in_ext > acc_q[g]) ? in_ext : acc_q[g];
			end else begin
				acc_next = acc_q[g] + in_ext;	// Cannot overflow within 2**MAX_WIN_SHIFT
			end
		end

		always_ff @(posedge clk) begin
			if (take) begin
				acc_q[g] <= acc_next;
				if (win_last) begin
					res_q[g] <= is_max ? acc_next[`DATA_W-1:0] : acc_shr[`DATA_W-1:0];
				end
			end
		end
	end

	// Lane 0 goes out first
	always_comb begin
		for (int l = 0; l < `BURST_LEN; l++) begin
			o_atom[l] = res_q[l];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			win_cnt <= '0;
			o_valid <= 1'b0;
		end else begin
			if (take) begin
				win_cnt <= win_last ? '0 : win_cnt + 1'b1;
			end
			if (take && win_last) begin
				o_valid <= 1'b1;	// Push the cycle after the last atom
			end else if (i_ready) begin
				o_valid <= 1'b0;
			end
		end
	end

	// Host must keep the window inside the accumulator width
	a_win_shift: assert property (@(posedge clk) disable iff (rst)
		i_busy |-> (i_cfg.win_shift <= `MAX_WIN_SHIFT));

endmodule

// File: pool_params.svh
`ifndef POOL_PARAMS_SVH
`define POOL_PARAMS_SVH

// Datapath geometry
`define BURST_LEN     16	// Channel lanes per atom
`define DATA_W        16	// Bits per channel word

// Largest window is 2**MAX_WIN_SHIFT atoms
`define MAX_WIN_SHIFT 4

// Buffering and flow control
`define IN_DEPTH      4	// Input word FIFO, equals host credits after reset
`define OUT_DEPTH     2	// Result FIFO depth in atoms
`define OUT_CREDITS   4	// Words the serializer may send before a credit returns

`endif

// File: pool_pkg.sv
`include "pool_params.svh"

package pool_pkg;

	// One channel value as it travels on the word streams
	typedef logic [`DATA_W-1:0] word_t;

	// One value per channel, index 0 is the first word on the stream
	typedef word_t [`BURST_LEN-1:0] atom_t;

	// Lane accumulator, wide enough for a full window sum
	typedef logic [`DATA_W+`MAX_WIN_SHIFT-1:0] sum_t;

	// Pooling operation
	typedef enum logic {
		POOL_MAX = 1'b0,	// Largest unsigned value in the window
		POOL_AVE = 1'b1	// Window sum shifted right by win_shift
	} pool_op_e;

	// Layer configuration, latched on start
	typedef struct packed {
		pool_op_e    op;
		logic [2:0]  win_shift;	// Window is 2**win_shift atoms
		logic [15:0] n_windows;	// Windows in the layer
	} pool_cfg_t;

endpackage

// File: sim.f
+incdir+.
pool_pkg.sv
credit_fifo.sv
atom_deserializer.sv
pool_lane_array.sv
atom_serializer.sv
pool_ctrl.sv
pool_engine.sv
tb_pool_engine.sv

// File: tb_pool_engine.sv
`timescale 1ns/100ps
`include "pool_params.svh"

module tb_pool_engine;

	// One row of the stimulus table
	typedef struct packed {
		pool_pkg::pool_cfg_t cfg;
		logic [7:0]          stall_pct;	// Chance in percent that a credit return starts a stall
	} row_t;

	logic                clk = 1'b0;
	logic                rst;
	logic                i_start;
	pool_pkg::pool_cfg_t i_cfg;
	logic                i_in_valid;
	pool_pkg::word_t     i_in_data;
	logic                o_in_credit;
	logic                o_out_valid;
	pool_pkg::word_t     o_out_data;
	logic                i_out_credit;
	logic                o_busy;
	logic                o_done;

	row_t        rows[$];
	string       names[$];
	logic [31:0] rng = 32'd80065;	// Xorshift state
	int          errors = 0;
	int          layers = 0;
	int          in_credits = `IN_DEPTH;	// Host side input credits
	int          owed = 0;	// Output words taken, credit not yet given back
	int          stall_left = 0;	// Cycles left in the current receiver stall
	bit          timed_out = 1'b0;

	pool_engine i_dut (
		.clk(clk), .rst(rst), .i_start(i_start), .i_cfg(i_cfg),
		.i_in_valid(i_in_valid), .i_in_data(i_in_data), .o_in_credit(o_in_credit),
		.o_out_valid(o_out_valid), .o_out_data(o_out_data), .i_out_credit(i_out_credit),
		.o_busy(o_busy), .o_done(o_done)
	);

	always #4 clk = ~clk;	// 8 ns period

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_word(input string name, input pool_pkg::word_t exp,
		input pool_pkg::word_t act);
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			errors++;
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic add_row(input pool_pkg::pool_op_e op, input int ws, input int n,
		input int stall, input string name);
		row_t row;
		row.cfg.op        = op;
		row.cfg.win_shift = 3'(ws);
		row.cfg.n_windows = 16'(n);
		row.stall_pct     = 8'(stall);
		rows.push_back(row);
		names.push_back(name);
	endtask

	task automatic load_table();
		add_row(pool_pkg::POOL_MAX, 2, 3, 0, "max_win4");
		add_row(pool_pkg::POOL_AVE, 3, 2, 0, "ave_win8");
		add_row(pool_pkg::POOL_MAX, 0, 4, 0, "max_pass");
		add_row(pool_pkg::POOL_AVE, 0, 4, 0, "ave_pass");
		add_row(pool_pkg::POOL_AVE, 4, 2, 35, "ave_win16_stall");
		add_row(pool_pkg::POOL_MAX, 1, 6, 50, "max_win2_stall");
		add_row(pool_pkg::POOL_MAX, 2, 2, 0, "max_win4_again");	// Second layer after a stalled one
	endtask

	// Receiver side, gives back one credit per cycle unless stalled
	task automatic return_credit(input int stall_pct);
		i_out_credit = 1'b0;
		if (owed == 0) begin
			return;
		end
		if (stall_left > 0) begin
			stall_left--;
		end else begin
			rng = xorshift(rng);
			if ((rng % 100) < stall_pct) begin
				rng = xorshift(rng);
				stall_left = 4 + (rng % 40);	// Long stretch without credits
			end else begin
				i_out_credit = 1'b1;
				owed--;
			end
		end
	endtask

	task automatic run_layer(input int idx);
		pool_pkg::pool_cfg_t cfg;
		string               name;
		int                  win_len;
		int                  n_words;
		int                  sent;
		int                  got;
		int                  pulses;
		int                  dones;
		int                  cyc;
		int                  limit;
		int                  w;
		int                  l;
		int                  a;
		logic [31:0]         acc;
		pool_pkg::word_t     val;
		pool_pkg::word_t     in_q[$];
		pool_pkg::word_t     exp_q[$];
		bit                  finished;
		bit                  credit_seen;

		cfg      = rows[idx].cfg;
		name     = names[idx];
		win_len  = 1 << cfg.win_shift;
		n_words  = int'(cfg.n_windows) * win_len * `BURST_LEN;
		sent     = 0;
		got      = 0;
		pulses   = 0;
		dones    = 0;
		cyc      = 0;
		limit    = 2000 + 30 * n_words;
		finished = 1'b0;
		for (w = 0; w < n_words; w++) begin
			rng = xorshift(rng);
			in_q.push_back(rng[`DATA_W-1:0]);
		end
		// Word a*BURST_LEN+l carries lane l of atom a
		for (w = 0; w < int'(cfg.n_windows); w++) begin
			for (l = 0; l < `BURST_LEN; l++) begin
				acc = '0;
				for (a = w * win_len; a < (w + 1) * win_len; a++) begin
					val = in_q[a * `BURST_LEN + l];
					if (cfg.op == pool_pkg::POOL_MAX) begin
						acc = (val > acc) ? val : acc;
					end else begin
						acc = acc + val;
					end
				end
				if (cfg.op == pool_pkg::POOL_AVE) begin
					acc = acc >> cfg.win_shift;	// Floor divide
				end
				exp_q.push_back(acc[`DATA_W-1:0]);
			end
		end

		i_cfg   = cfg;
		i_start = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
		while (!finished && cyc < limit) begin
			cyc++;
			credit_seen = o_in_credit;
			if (o_out_valid) begin
				owed++;
				got++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("%s: extra output word %h after the last expected one", name,
						o_out_data);
				end else begin
					check_word($sformatf("%s word %0d", name, got - 1), exp_q.pop_front(),
						o_out_data);
				end
			end
			if (o_done) begin
				finished = 1'b1;
				dones++;
				check_flag({name, " busy with done"}, 1'b0, o_busy);
				check_count({name, " words missing at done"}, 0, exp_q.size());
			end else if (!o_busy) begin
				errors++;
				$display("%s: o_busy fell without o_done", name);
				finished = 1'b1;
			end
			// A credit seen now frees its entry only at the coming edge
			i_in_valid = 1'b0;
			if (in_credits > 0 && sent < n_words) begin
				i_in_valid = 1'b1;
				i_in_data  = in_q[sent];
				sent++;
				in_credits--;
			end
			if (credit_seen) begin
				in_credits++;
				pulses++;
			end
			return_credit(rows[idx].stall_pct);
			@(negedge clk);
		end
		i_in_valid = 1'b0;
		if (!finished) begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout waiting for o_done of layer %s", name);
			return;
		end

		// Give back the remaining output credits and watch for late activity
		cyc = 0;
		while ((owed > 0 || cyc < 4) && cyc < limit) begin
			cyc++;
			if (o_out_valid) begin
				errors++;
				$display("%s: output word after o_done", name);
			end
			if (o_done) begin
				dones++;	// A second pulse fails the count below
			end
			if (o_in_credit) begin
				in_credits++;
				pulses++;
			end
			return_credit(rows[idx].stall_pct);
			@(negedge clk);
		end
		i_out_credit = 1'b0;
		if (owed > 0) begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout returning output credits after layer %s", name);
			return;
		end
		check_count({name, " input credit pulses"}, n_words, pulses);
		check_count({name, " host credits"}, `IN_DEPTH, in_credits);
		check_count({name, " output words"}, int'(cfg.n_windows) * `BURST_LEN, got);
		check_count({name, " done pulses"}, 1, dones);
		layers++;
	endtask

	initial begin
		int r;
		rst          = 1'b1;
		i_start      = 1'b0;
		i_cfg        = '0;
		i_in_valid   = 1'b0;
		i_in_data    = '0;
		i_out_credit = 1'b0;
		load_table();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_flag("reset o_out_valid", 1'b0, o_out_valid);
		check_flag("reset o_in_credit", 1'b0, o_in_credit);
		check_flag("reset o_busy", 1'b0, o_busy);
		check_flag("reset o_done", 1'b0, o_done);
		for (r = 0; r < rows.size(); r++) begin
			if (!timed_out) begin
				run_layer(r);
			end
		end
		$display("Errors: %0d, layers completed: %0d of %0d", errors, layers, rows.size());
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
